// ==== logic/fpga_pkg.sv ====
// Constants assume a 125 MHz core clock. FIFO_DEPTH must be a power of two
package fpga_pkg;

    // UART bit timing for 8N1 at BAUD_RATE
    localparam int CLK_FREQ_HZ   = 125000000;
    localparam int BAUD_RATE     = 115200;
    localparam int CLKS_PER_BIT  = CLK_FREQ_HZ / BAUD_RATE;
    localparam int HALF_BIT_CLKS = CLKS_PER_BIT / 2;
    localparam int BIT_CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int BYTE_W        = 8;

    // Switch and button debounce
    localparam int DEBOUNCE_RATE = 125000;
    localparam int DEBOUNCE_N    = 4;
    localparam int TICK_CNT_W    = $clog2(DEBOUNCE_RATE);

    // Echo buffer between receiver and transmitter
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // Flip-flops per input synchronizer
    localparam int SYNC_STAGES = 2;

endpackage

// ==== logic/uart_rx.sv ====
// Expects rxd already synchronized; no parity, and a low stop bit silently drops the byte
module uart_rx
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic                 rxd_q;
    logic                 busy;
    logic [3:0]           bit_idx;
    logic [BIT_CNT_W-1:0] cyc_cnt;
    logic [BIT_CNT_W-1:0] cyc_limit;
    logic                 bit_end;
    logic [7:0]           shift_reg;

    // Index 0 is the start bit, 1 to 8 data, 9 the stop bit
    // Start bit is checked after half a bit and the rest a full bit apart
    assign cyc_limit = (bit_idx == 4'd0) ? BIT_CNT_W'(HALF_BIT_CLKS - 1)
                                         : BIT_CNT_W'(CLKS_PER_BIT - 1);
    assign bit_end   = busy && (cyc_cnt == cyc_limit);
    assign rx_data   = shift_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_q    <= 1'b1;
            busy     <= 1'b0;
            bit_idx  <= 4'd0;
            cyc_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_q    <= rxd;
            rx_valid <= 1'b0;
            if (!busy) begin
                // Falling edge opens a frame
                if (rxd_q && !rxd) begin
                    busy    <= 1'b1;
                    bit_idx <= 4'd0;
                    cyc_cnt <= '0;
                end
            end else if (!bit_end) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end else begin
                cyc_cnt <= '0;
                if (bit_idx == 4'd0) begin
                    // Line high again at mid start bit means a glitch
                    if (rxd) begin
                        busy <= 1'b0;
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rxd;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bit_end && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shift_reg <= {rxd, shift_reg[7:1]};
        end
    end

endmodule

// ==== logic/byte_fifo.sv ====
// First-word fall-through; writes when full and reads when empty are dropped with no flag
module byte_fifo
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;

    // Head entry is always on the output
    assign rd_data = mem[rd_ptr];

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
// One idle cycle separates back-to-back frames; no flow control toward the line
module uart_tx
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] fifo_data,
    input  logic       fifo_empty,
    output logic       fifo_rd,
    output logic       txd
);

    logic                 busy;
    logic [3:0]           bit_cnt;
    logic [BIT_CNT_W-1:0] cyc_cnt;
    logic                 bit_end;
    logic [8:0]           shift_reg;

    // Pop as soon as idle with data waiting
    assign fifo_rd = !busy && !fifo_empty;
    assign bit_end = busy && (cyc_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= 4'd0;
            cyc_cnt <= '0;
            txd     <= 1'b1;
        end else if (fifo_rd) begin
            // Start bit goes out right away
            busy    <= 1'b1;
            bit_cnt <= 4'd0;
            cyc_cnt <= '0;
            txd     <= 1'b0;
        end else if (busy) begin
            if (!bit_end) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end else begin
                cyc_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // Stop bit done with the line still high
                    busy <= 1'b0;
                end else begin
                    txd     <= shift_reg[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Data goes out LSB first with the stop bit parked on top
    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            shift_reg <= {1'b1, fifo_data};
        end else if (bit_end) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

endmodule

// ==== logic/debounce_switch.sv ====
// Raw inputs are sampled directly at the slow tick, so each pin must settle within one tick
module debounce_switch
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] raw,
    output logic [7:0] clean
);

    logic [TICK_CNT_W-1:0]      tick_cnt;
    logic                       tick;
    logic [7:0][DEBOUNCE_N-1:0] hist;

    assign tick = (tick_cnt == TICK_CNT_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            hist     <= '0;
            clean    <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            for (int i = 0; i < 8; i++) begin
                if (tick) begin
                    hist[i] <= {hist[i][DEBOUNCE_N-2:0], raw[i]};
                end
                // Output moves only on a unanimous history
                if (&hist[i]) begin
                    clean[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    clean[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== logic/fpga_core.sv ====
// Inputs must already be synchronous to clk; LEDs show only the low nibble of the last byte
module fpga_core
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    input  logic [3:0] sw,
    input  logic [3:0] btn,
    output logic       led0_r,
    output logic       led0_g,
    output logic       led1_r,
    output logic       led1_g,
    output logic       led2_r,
    output logic       led2_g,
    output logic       led3_r,
    output logic       led3_g,
    output logic       led4,
    output logic       led5,
    output logic       led6,
    output logic       led7,
    output logic       txd
);

    logic [BYTE_W-1:0] rx_data;
    logic              rx_valid;
    logic [BYTE_W-1:0] fifo_data;
    logic              fifo_empty;
    logic              fifo_rd;
    logic [3:0]        sw_db;
    logic [3:0]        btn_db;
    logic [3:0]        last_nib;

    // Echo path
    uart_rx rx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    byte_fifo fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rx_valid),
        .wr_data (rx_data),
        .rd_en   (fifo_rd),
        .rd_data (fifo_data),
        .empty   (fifo_empty)
    );

    uart_tx tx_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .txd        (txd)
    );

    debounce_switch debounce_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   ({btn, sw}),
        .clean ({btn_db, sw_db})
    );

    // Buttons drive the red LEDs and switches the green
    assign {led3_r, led2_r, led1_r, led0_r} = btn_db;
    assign {led3_g, led2_g, led1_g, led0_g} = sw_db;

    // Low nibble of the last received byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_nib <= 4'd0;
        end else if (rx_valid) begin
            last_nib <= rx_data[3:0];
        end
    end

    assign {led7, led6, led5, led4} = last_nib;

endmodule

// ==== logic/fpga.sv ====
// No clock buffering on clk; reset follows the button after SYNC_STAGES cycles
module fpga
    import fpga_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic [3:0] sw,
    input  logic [3:0] btn,
    input  logic       uart_rxd,
    output logic       led0_r,
    output logic       led0_g,
    output logic       led1_r,
    output logic       led1_g,
    output logic       led2_r,
    output logic       led2_g,
    output logic       led3_r,
    output logic       led3_g,
    output logic       led4,
    output logic       led5,
    output logic       led6,
    output logic       led7,
    output logic       uart_txd
);

    logic [SYNC_STAGES-1:0] rst_sync;
    logic [SYNC_STAGES-1:0] rxd_sync_q;
    logic                   rst_n;
    logic                   rxd_sync;

    // Button reset held low for as long as it is pressed
    always_ff @(posedge clk) begin
        rst_sync <= {rst_sync[SYNC_STAGES-2:0], reset_n};
    end

    assign rst_n = rst_sync[SYNC_STAGES-1];

    // UART line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_sync_q <= '1;
        end else begin
            rxd_sync_q <= {rxd_sync_q[SYNC_STAGES-2:0], uart_rxd};
        end
    end

    assign rxd_sync = rxd_sync_q[SYNC_STAGES-1];

    fpga_core core_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rxd    (rxd_sync),
        .sw     (sw),
        .btn    (btn),
        .led0_r (led0_r),
        .led0_g (led0_g),
        .led1_r (led1_r),
        .led1_g (led1_g),
        .led2_r (led2_r),
        .led2_g (led2_g),
        .led3_r (led3_r),
        .led3_g (led3_g),
        .led4   (led4),
        .led5   (led5),
        .led6   (led6),
        .led7   (led7),
        .txd    (uart_txd)
    );

endmodule

// ==== verification/tb_fpga.sv ====
// Full package timing (1085 clocks per UART bit, 125000 per debounce sample), about 1M cycles
module tb_fpga
    import fpga_pkg::*;
();

    localparam int FRAME_CLKS     = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = (FIFO_DEPTH + 8) * FRAME_CLKS
                                  + (DEBOUNCE_N + 4) * DEBOUNCE_RATE;

    logic       clk;
    logic       reset_n;
    logic [3:0] sw;
    logic [3:0] btn;
    logic       uart_rxd;
    logic       uart_txd;
    logic       led0_r, led1_r, led2_r, led3_r;
    logic       led0_g, led1_g, led2_g, led3_g;
    logic       led4, led5, led6, led7;
    logic [3:0] red_leds;
    logic [3:0] green_leds;
    logic [3:0] byte_leds;

    int         cycle_count = 0;
    logic [7:0] burst_bytes [FIFO_DEPTH];
    logic [7:0] echo_bytes  [FIFO_DEPTH];

    assign red_leds   = {led3_r, led2_r, led1_r, led0_r};
    assign green_leds = {led3_g, led2_g, led1_g, led0_g};
    assign byte_leds  = {led7, led6, led5, led4};

    fpga UUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .sw       (sw),
        .btn      (btn),
        .uart_rxd (uart_rxd),
        .led0_r   (led0_r),
        .led0_g   (led0_g),
        .led1_r   (led1_r),
        .led1_g   (led1_g),
        .led2_r   (led2_r),
        .led2_g   (led2_g),
        .led3_r   (led3_r),
        .led3_g   (led3_g),
        .led4     (led4),
        .led5     (led5),
        .led6     (led6),
        .led7     (led7),
        .uart_txd (uart_txd)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Leaves the caller 1 unit after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic uart_send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rxd = frame[i];
            wait_cycles(CLKS_PER_BIT);
        end
    endtask

    // Samples at mid-bit on falling clock edges and returns at mid stop bit
    task automatic uart_recv_byte(input string test_name, output logic [7:0] data);
        @(negedge uart_txd);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check_value({test_name, " start bit"}, 32'd0, uart_txd);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value({test_name, " stop bit"}, 32'd1, uart_txd);
    endtask

    task automatic idle_after_reset();
        check_value("reset_state txd", 32'd1, uart_txd);
        check_value("reset_state red", 32'd0, red_leds);
        check_value("reset_state green", 32'd0, green_leds);
        check_value("reset_state byte", 32'd0, byte_leds);
    endtask

    task automatic single_byte_echo();
        logic [7:0] echoed;
        fork
            uart_send_byte(8'h5a);
            uart_recv_byte("single_echo", echoed);
        join
        wait_cycles(1);
        check_value("single_echo byte", 32'h5a, echoed);
        check_value("single_echo leds", 32'ha, byte_leds);
    endtask

    task automatic burst_echo();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            burst_bytes[i] = 8'($urandom());
        end
        fork
            begin
                for (int i = 0; i < FIFO_DEPTH; i++) begin
                    uart_send_byte(burst_bytes[i]);
                end
            end
            begin
                for (int i = 0; i < FIFO_DEPTH; i++) begin
                    uart_recv_byte("burst_echo", echo_bytes[i]);
                end
            end
        join
        wait_cycles(1);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_value($sformatf("burst_echo byte %0d", i), burst_bytes[i], echo_bytes[i]);
        end
        check_value("burst_echo leds", burst_bytes[FIFO_DEPTH-1][3:0], byte_leds);
    endtask

    task automatic start_glitch_rejected();
        logic line_min;
        // Let the last echoed stop bit run out
        wait_cycles(CLKS_PER_BIT);
        uart_rxd = 1'b0;
        wait_cycles(CLKS_PER_BIT / 4);
        uart_rxd = 1'b1;
        line_min = 1'b1;
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk);
            line_min = line_min & uart_txd;
        end
        wait_cycles(1);
        check_value("start_glitch txd", 32'd1, line_min);
        check_value("start_glitch leds", burst_bytes[FIFO_DEPTH-1][3:0], byte_leds);
    endtask

    task automatic debounce_switches();
        sw  = 4'b1010;
        btn = 4'b0110;
        wait_cycles((DEBOUNCE_N + 1) * DEBOUNCE_RATE);
        check_value("debounce green", 32'b1010, green_leds);
        check_value("debounce red", 32'b0110, red_leds);
        // Short drop that at most one sample sees
        sw = 4'b0000;
        wait_cycles(DEBOUNCE_RATE / 2);
        sw = 4'b1010;
        check_value("debounce pulse green", 32'b1010, green_leds);
        wait_cycles(DEBOUNCE_RATE);
        check_value("debounce hold green", 32'b1010, green_leds);
        check_value("debounce hold red", 32'b0110, red_leds);
    endtask

    initial begin
        clk      = 1'b0;
        reset_n  = 1'b0;
        sw       = 4'b0000;
        btn      = 4'b0000;
        uart_rxd = 1'b1;
        void'($urandom(32'hd620_b393));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // Reset synchronizer releases a few cycles later
        wait_cycles(SYNC_STAGES + 2);
        idle_after_reset();
        single_byte_echo();
        burst_echo();
        start_glitch_rejected();
        debounce_switches();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
logic/fpga_pkg.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/debounce_switch.sv
logic/fpga_core.sv
logic/fpga.sv
verification/tb_fpga.sv

// ==== Bender.yml ====
package:
  name: fpga_uart_echo

sources:
  - logic/fpga_pkg.sv
  - logic/uart_rx.sv
  - logic/byte_fifo.sv
  - logic/uart_tx.sv
  - logic/debounce_switch.sv
  - logic/fpga_core.sv
  - logic/fpga.sv
  - target: simulation
    files:
      - verification/tb_fpga.sv
